// ==== src/rc4_settings.svh ====
`ifndef RC4_SETTINGS_SVH
`define RC4_SETTINGS_SVH

// ############################################################
// engine sizing
// ############################################################

// key bytes go msb first
`define RC4_KEY_BYTES 3
`define RC4_FIFO_DEPTH 32
`define RC4_LEN_W 6

// ############################################################
// register map
// ############################################################

`define RC4_REG_KEY    4'h0
`define RC4_REG_CTRL   4'h4
`define RC4_REG_STATUS 4'h8
`define RC4_REG_DATA   4'hC

`endif

// ==== src/rc4_pkg.sv ====
`default_nettype none
`include "rc4_settings.svh"

package rc4_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [`RC4_KEY_BYTES*8-1:0] key_t;
	typedef logic [`RC4_LEN_W-1:0] len_t;
	typedef logic [3:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;

	// master side of the AXI4-Lite port
	typedef struct packed {
		axil_addr_t aw_addr;
		logic       aw_valid;
		axil_data_t w_data;
		logic [3:0] w_strb;
		logic       w_valid;
		logic       b_ready;
		axil_addr_t ar_addr;
		logic       ar_valid;
		logic       r_ready;
	} axil_req_t;

	typedef struct packed {
		logic       aw_ready;
		logic       w_ready;
		logic [1:0] b_resp;
		logic       b_valid;
		logic       ar_ready;
		axil_data_t r_data;
		logic [1:0] r_resp;
		logic       r_valid;
	} axil_rsp_t;

	typedef struct packed {
		key_t key;
		len_t len;
		logic start;
	} rc4_cmd_t;

	typedef struct packed {
		byte_t addr;
		byte_t wdata;
		logic  we;
	} ram_port_t;

	typedef enum logic [4:0] {
		eng_idle,
		eng_init_wr,
		eng_rd_i,
		eng_wait_i,
		eng_wait_i2,
		eng_save_i,
		eng_key_sel,
		eng_set_j,
		eng_rd_j,
		eng_wait_j,
		eng_wait_j2,
		eng_save_j,
		eng_wr_i,
		eng_wr_j,
		eng_gen_inc,
		eng_gen_sum,
		eng_gen_wait,
		eng_gen_wait2,
		eng_push,
		eng_done
	} eng_state_e;

endpackage

`default_nettype wire

// ==== src/rc4_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rc4_settings.svh"

module rc4_reg_decode (
	input  wire                    clk,
	input  wire                    rst_n_i,
	input  wire rc4_pkg::axil_req_t axil_req_i,
	output rc4_pkg::axil_rsp_t     axil_rsp_o,
	output rc4_pkg::rc4_cmd_t      cmd_o,
	input  wire                    busy_i,
	input  wire                    done_i,
	input  wire rc4_pkg::byte_t    fifo_count_i,
	input  wire rc4_pkg::byte_t    fifo_data_i,
	input  wire                    fifo_empty_i,
	output logic                   fifo_pop_o
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic                 wr_ready_q;
	logic                 rd_ready_q;
	logic                 b_valid_q;
	logic                 r_valid_q;
	logic                 start_q;
	logic [1:0]           b_resp_q;
	logic [1:0]           r_resp_q;
	rc4_pkg::axil_data_t  r_data_q;
	rc4_pkg::key_t        key_q;
	rc4_pkg::len_t        len_q;
	logic                 ctrl_start;
	logic                 wr_err;
	logic                 rd_err;
	rc4_pkg::axil_data_t  rd_data;

	// ############################################################
	// address decode
	// ############################################################

	always_comb begin
		ctrl_start = 1'b0;
		wr_err     = 1'b0;
		case (axil_req_i.aw_addr)
			`RC4_REG_KEY: begin
				wr_err = 1'b0;
			end
			`RC4_REG_CTRL: begin
				ctrl_start = axil_req_i.w_data[0];
				// start refused while a run is in progress
				wr_err     = axil_req_i.w_data[0] & busy_i;
			end
			default: begin
				wr_err = 1'b1;
			end
		endcase
	end

	always_comb begin
		rd_err  = 1'b0;
		rd_data = '0;
		case (axil_req_i.ar_addr)
			`RC4_REG_KEY: begin
				rd_data = rc4_pkg::axil_data_t'(key_q);
			end
			`RC4_REG_CTRL: begin
				rd_data = '0;
			end
			`RC4_REG_STATUS: begin
				rd_data = {16'h0, fifo_count_i, 6'h0, done_i, busy_i};
			end
			`RC4_REG_DATA: begin
				if (fifo_empty_i) begin
					rd_err = 1'b1;
				end else begin
					rd_data = {24'h0, fifo_data_i};
				end
			end
			default: begin
				rd_err = 1'b1;
			end
		endcase
	end

	// pop in the read acceptance cycle
	assign fifo_pop_o = rd_ready_q && (axil_req_i.ar_addr == `RC4_REG_DATA) && !fifo_empty_i;

	// ############################################################
	// handshake state
	// ############################################################

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ready_q <= 1'b0;
			rd_ready_q <= 1'b0;
			b_valid_q  <= 1'b0;
			r_valid_q  <= 1'b0;
			start_q    <= 1'b0;
		end else begin
			wr_ready_q <= axil_req_i.aw_valid && axil_req_i.w_valid && !wr_ready_q && !b_valid_q;
			rd_ready_q <= axil_req_i.ar_valid && !rd_ready_q && !r_valid_q;
			start_q    <= wr_ready_q && ctrl_start && !wr_err;
			if (wr_ready_q) begin
				b_valid_q <= 1'b1;
			end else if (axil_req_i.b_ready) begin
				b_valid_q <= 1'b0;
			end
			if (rd_ready_q) begin
				r_valid_q <= 1'b1;
			end else if (axil_req_i.r_ready) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ready_q) begin
			b_resp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
			if (axil_req_i.aw_addr == `RC4_REG_KEY) begin
				key_q <= axil_req_i.w_data[`RC4_KEY_BYTES*8-1:0];
			end
			if (ctrl_start && !wr_err) begin
				len_q <= axil_req_i.w_data[`RC4_LEN_W:1];
			end
		end
		if (rd_ready_q) begin
			r_resp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
			r_data_q <= rd_data;
		end
	end

	always_comb begin
		axil_rsp_o.aw_ready = wr_ready_q;
		axil_rsp_o.w_ready  = wr_ready_q;
		axil_rsp_o.b_resp   = b_resp_q;
		axil_rsp_o.b_valid  = b_valid_q;
		axil_rsp_o.ar_ready = rd_ready_q;
		axil_rsp_o.r_data   = r_data_q;
		axil_rsp_o.r_resp   = r_resp_q;
		axil_rsp_o.r_valid  = r_valid_q;
	end

	assign cmd_o.key   = key_q;
	assign cmd_o.len   = len_q;
	assign cmd_o.start = start_q;

endmodule

`default_nettype wire

// ==== src/rc4_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rc4_settings.svh"

module rc4_engine (
	input  wire                    clk,
	input  wire                    rst_n_i,
	input  wire rc4_pkg::rc4_cmd_t cmd_i,
	output rc4_pkg::ram_port_t     ram_o,
	input  wire rc4_pkg::byte_t    ram_rdata_i,
	output logic                   push_valid_o,
	output rc4_pkg::byte_t         push_data_o,
	input  wire                    fifo_full_i,
	output logic                   flush_o,
	output logic                   busy_o,
	output logic                   done_o
);

	localparam int KEY_IDX_W = $clog2(`RC4_KEY_BYTES);

	rc4_pkg::eng_state_e   state_q;
	logic                  gen_q;
	rc4_pkg::byte_t        i_q;
	rc4_pkg::byte_t        j_q;
	rc4_pkg::byte_t        si_q;
	rc4_pkg::byte_t        sj_q;
	rc4_pkg::byte_t        key_byte_q;
	logic [KEY_IDX_W-1:0]  k_q;
	rc4_pkg::key_t         key_q;
	rc4_pkg::len_t         left_q;
	rc4_pkg::ram_port_t    ram_q;
	logic                  flush_q;

	assign ram_o        = ram_q;
	assign flush_o      = flush_q;
	assign busy_o       = (state_q != rc4_pkg::eng_idle) && (state_q != rc4_pkg::eng_done);
	assign done_o       = (state_q == rc4_pkg::eng_done);
	// output byte sits on the ram read port while in push
	assign push_valid_o = (state_q == rc4_pkg::eng_push) && !fifo_full_i;
	assign push_data_o  = ram_rdata_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= rc4_pkg::eng_idle;
			gen_q      <= 1'b0;
			i_q        <= '0;
			j_q        <= '0;
			si_q       <= '0;
			sj_q       <= '0;
			key_byte_q <= '0;
			k_q        <= '0;
			key_q      <= '0;
			left_q     <= '0;
			ram_q      <= '0;
			flush_q    <= 1'b0;
		end else begin
			ram_q.we <= 1'b0;
			flush_q  <= 1'b0;
			case (state_q)
				rc4_pkg::eng_idle, rc4_pkg::eng_done: begin
					if (cmd_i.start) begin
						key_q   <= cmd_i.key;
						left_q  <= cmd_i.len;
						i_q     <= '0;
						flush_q <= 1'b1;
						state_q <= rc4_pkg::eng_init_wr;
					end
				end

				// ############################################################
				// identity fill at one entry per cycle
				// ############################################################
				rc4_pkg::eng_init_wr: begin
					ram_q.addr  <= i_q;
					ram_q.wdata <= i_q;
					ram_q.we    <= 1'b1;
					i_q         <= i_q + 8'd1;
					if (i_q == 8'hff) begin
						j_q     <= '0;
						k_q     <= '0;
						gen_q   <= 1'b0;
						state_q <= rc4_pkg::eng_rd_i;
					end
				end

				// ############################################################
				// swap loop shared by key schedule and generation
				// ############################################################
				rc4_pkg::eng_rd_i: begin
					ram_q.addr <= i_q;
					state_q    <= rc4_pkg::eng_wait_i;
				end
				rc4_pkg::eng_wait_i:  state_q <= rc4_pkg::eng_wait_i2;
				rc4_pkg::eng_wait_i2: state_q <= rc4_pkg::eng_save_i;
				rc4_pkg::eng_save_i: begin
					si_q    <= ram_rdata_i;
					state_q <= gen_q ? rc4_pkg::eng_set_j : rc4_pkg::eng_key_sel;
				end
				rc4_pkg::eng_key_sel: begin
					key_byte_q <= key_q[(`RC4_KEY_BYTES - 1 - k_q) * 8 +: 8];
					k_q        <= (k_q == KEY_IDX_W'(`RC4_KEY_BYTES - 1)) ? '0 : k_q + 1'b1;
					state_q    <= rc4_pkg::eng_set_j;
				end
				rc4_pkg::eng_set_j: begin
					// no key term during generation
					j_q     <= j_q + si_q + (gen_q ? 8'd0 : key_byte_q);
					state_q <= rc4_pkg::eng_rd_j;
				end
				rc4_pkg::eng_rd_j: begin
					ram_q.addr <= j_q;
					state_q    <= rc4_pkg::eng_wait_j;
				end
				rc4_pkg::eng_wait_j:  state_q <= rc4_pkg::eng_wait_j2;
				rc4_pkg::eng_wait_j2: state_q <= rc4_pkg::eng_save_j;
				rc4_pkg::eng_save_j: begin
					sj_q    <= ram_rdata_i;
					state_q <= rc4_pkg::eng_wr_i;
				end
				rc4_pkg::eng_wr_i: begin
					ram_q.addr  <= i_q;
					ram_q.wdata <= sj_q;
					ram_q.we    <= 1'b1;
					state_q     <= rc4_pkg::eng_wr_j;
				end
				rc4_pkg::eng_wr_j: begin
					ram_q.addr  <= j_q;
					ram_q.wdata <= si_q;
					ram_q.we    <= 1'b1;
					if (gen_q) begin
						state_q <= rc4_pkg::eng_gen_sum;
					end else if (i_q == 8'hff) begin
						i_q     <= '0;
						j_q     <= '0;
						gen_q   <= 1'b1;
						state_q <= rc4_pkg::eng_gen_inc;
					end else begin
						i_q     <= i_q + 8'd1;
						state_q <= rc4_pkg::eng_rd_i;
					end
				end

				// ############################################################
				// keystream output
				// ############################################################
				rc4_pkg::eng_gen_inc: begin
					if (left_q == '0) begin
						state_q <= rc4_pkg::eng_done;
					end else begin
						i_q     <= i_q + 8'd1;
						state_q <= rc4_pkg::eng_rd_i;
					end
				end
				rc4_pkg::eng_gen_sum: begin
					ram_q.addr <= si_q + sj_q;
					state_q    <= rc4_pkg::eng_gen_wait;
				end
				rc4_pkg::eng_gen_wait:  state_q <= rc4_pkg::eng_gen_wait2;
				rc4_pkg::eng_gen_wait2: state_q <= rc4_pkg::eng_push;
				rc4_pkg::eng_push: begin
					// hold here while the fifo is full
					if (!fifo_full_i) begin
						left_q  <= left_q - 1'b1;
						state_q <= rc4_pkg::eng_gen_inc;
					end
				end
				default: state_q <= rc4_pkg::eng_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/rc4_state_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module rc4_state_ram (
	input  wire                     clk,
	input  wire rc4_pkg::ram_port_t ram_i,
	output rc4_pkg::byte_t          rdata_o
);

	rc4_pkg::byte_t mem_q [256];
	rc4_pkg::byte_t addr_q;

	always_ff @(posedge clk) begin
		if (ram_i.we) begin
			mem_q[ram_i.addr] <= ram_i.wdata;
		end
	end

	// address and data both registered for a two-cycle read
	always_ff @(posedge clk) begin
		addr_q  <= ram_i.addr;
		rdata_o <= mem_q[addr_q];
	end

endmodule

`default_nettype wire

// ==== src/rc4_keystream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rc4_settings.svh"

module rc4_keystream_fifo (
	input  wire                 clk,
	input  wire                 rst_n_i,
	input  wire                 flush_i,
	input  wire                 push_i,
	input  wire rc4_pkg::byte_t push_data_i,
	input  wire                 pop_i,
	output rc4_pkg::byte_t      pop_data_o,
	output logic                empty_o,
	output logic                full_o,
	output rc4_pkg::byte_t      count_o
);

	localparam int PTR_W = $clog2(`RC4_FIFO_DEPTH);

	rc4_pkg::byte_t   mem_q [`RC4_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W:0]   count_q;
	logic             do_push;
	logic             do_pop;

	assign do_push    = push_i && !full_o;
	assign do_pop     = pop_i && !empty_o;
	assign empty_o    = (count_q == '0);
	assign full_o     = (count_q == (PTR_W+1)'(`RC4_FIFO_DEPTH));
	assign count_o    = rc4_pkg::byte_t'(count_q);
	// first word falls through
	assign pop_data_o = mem_q[rd_ptr_q];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else if (flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (do_push && !do_pop) begin
				count_q <= count_q + 1'b1;
			end else if (do_pop && !do_push) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= push_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== src/rc4_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rc4_top (
	input  wire                     clk,
	input  wire                     rst_n_i,
	input  wire rc4_pkg::axil_req_t axil_req_i,
	output rc4_pkg::axil_rsp_t      axil_rsp_o
);

	rc4_pkg::rc4_cmd_t  cmd;
	rc4_pkg::ram_port_t ram_port;
	rc4_pkg::byte_t     ram_rdata;
	rc4_pkg::byte_t     push_data;
	rc4_pkg::byte_t     fifo_data;
	rc4_pkg::byte_t     fifo_count;
	logic               push_valid;
	logic               fifo_full;
	logic               fifo_empty;
	logic               fifo_pop;
	logic               flush;
	logic               busy;
	logic               done;

	rc4_reg_decode i_rc4_reg_decode (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.axil_req_i   (axil_req_i),
		.axil_rsp_o   (axil_rsp_o),
		.cmd_o        (cmd),
		.busy_i       (busy),
		.done_i       (done),
		.fifo_count_i (fifo_count),
		.fifo_data_i  (fifo_data),
		.fifo_empty_i (fifo_empty),
		.fifo_pop_o   (fifo_pop)
	);

	rc4_engine i_rc4_engine (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.cmd_i        (cmd),
		.ram_o        (ram_port),
		.ram_rdata_i  (ram_rdata),
		.push_valid_o (push_valid),
		.push_data_o  (push_data),
		.fifo_full_i  (fifo_full),
		.flush_o      (flush),
		.busy_o       (busy),
		.done_o       (done)
	);

	rc4_state_ram i_rc4_state_ram (
		.clk     (clk),
		.ram_i   (ram_port),
		.rdata_o (ram_rdata)
	);

	rc4_keystream_fifo i_rc4_keystream_fifo (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.flush_i     (flush),
		.push_i      (push_valid),
		.push_data_i (push_data),
		.pop_i       (fifo_pop),
		.pop_data_o  (fifo_data),
		.empty_o     (fifo_empty),
		.full_o      (fifo_full),
		.count_o     (fifo_count)
	);

endmodule

`default_nettype wire

// ==== tests/tb_rc4_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rc4_settings.svh"

module tb_rc4_top;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam int NUM_RUNS      = 14;
	// init and key schedule plus generation of the longest run
	localparam int RUN_CYCLES    = 256 * 16 + 24 * 64;
	localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES + 10000;

	logic               clk;
	logic               rst_n;
	rc4_pkg::axil_req_t req;
	rc4_pkg::axil_rsp_t rsp;

	int         err_count;
	int         test_errs_at_start;
	int         tests_run;
	int         tests_failed;
	string      cur_test;
	logic [7:0] s_ref [256];
	logic [7:0] exp_q [$];

	rc4_top i_rc4_top (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.axil_req_i (req),
		.axil_rsp_o (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("watchdog expired, the DUT stopped responding");
		$display("Simulation FAILED");
		$finish;
	end

	// responses stay valid until the master takes them
	assert property (@(posedge clk) disable iff (!rst_n)
		(rsp.b_valid && !req.b_ready) |=> rsp.b_valid)
	else begin
		$display("write response dropped before bready");
		err_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(rsp.r_valid && !req.r_ready) |=> rsp.r_valid)
	else begin
		$display("read response dropped before rready");
		err_count++;
	end

	// address and data of a write are taken in the same cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		rsp.aw_ready == rsp.w_ready)
	else begin
		$display("awready and wready did not rise together");
		err_count++;
	end

	// ############################################################
	// reference model
	// ############################################################

	task automatic fill_identity();
		for (int i = 0; i < 256; i++) begin
			s_ref[i] = i[7:0];
		end
	endtask

	task automatic schedule_key(input rc4_pkg::key_t key);
		int         j;
		int         shift;
		logic [7:0] kb;
		logic [7:0] t;
		j = 0;
		for (int i = 0; i < 256; i++) begin
			// first key byte is the top byte
			shift = (`RC4_KEY_BYTES - 1 - (i % `RC4_KEY_BYTES)) * 8;
			kb = 8'(key >> shift);
			j = (j + int'(s_ref[i]) + int'(kb)) % 256;
			t = s_ref[i];
			s_ref[i] = s_ref[j];
			s_ref[j] = t;
		end
	endtask

	task automatic generate_bytes(input int len);
		int         i;
		int         j;
		logic [7:0] t;
		i = 0;
		j = 0;
		for (int n = 0; n < len; n++) begin
			i = (i + 1) % 256;
			j = (j + int'(s_ref[i])) % 256;
			t = s_ref[i];
			s_ref[i] = s_ref[j];
			s_ref[j] = t;
			exp_q.push_back(s_ref[(int'(s_ref[i]) + int'(s_ref[j])) % 256]);
		end
	endtask

	task automatic build_expected(input rc4_pkg::key_t key, input int len);
		exp_q.delete();
		fill_identity();
		schedule_key(key);
		generate_bytes(len);
	endtask

	// ############################################################
	// AXI4-Lite master
	// ############################################################

	task automatic write_reg(input rc4_pkg::axil_addr_t addr, input rc4_pkg::axil_data_t data,
			output logic [1:0] resp);
		@(negedge clk);
		req.aw_addr  = addr;
		req.aw_valid = 1'b1;
		req.w_data   = data;
		req.w_strb   = 4'hf;
		req.w_valid  = 1'b1;
		@(negedge clk);
		while (!rsp.aw_ready) @(negedge clk);
		// accepted on the coming rising edge
		@(negedge clk);
		req.aw_valid = 1'b0;
		req.w_valid  = 1'b0;
		while (!rsp.b_valid) @(negedge clk);
		// bready comes a cycle late so the response has to wait
		@(negedge clk);
		req.b_ready = 1'b1;
		resp = rsp.b_resp;
		@(negedge clk);
		req.b_ready = 1'b0;
	endtask

	task automatic read_reg(input rc4_pkg::axil_addr_t addr, output rc4_pkg::axil_data_t data,
			output logic [1:0] resp);
		@(negedge clk);
		req.ar_addr  = addr;
		req.ar_valid = 1'b1;
		@(negedge clk);
		while (!rsp.ar_ready) @(negedge clk);
		@(negedge clk);
		req.ar_valid = 1'b0;
		while (!rsp.r_valid) @(negedge clk);
		// rready comes a cycle late so the response has to wait
		@(negedge clk);
		req.r_ready = 1'b1;
		data = rsp.r_data;
		resp = rsp.r_resp;
		@(negedge clk);
		req.r_ready = 1'b0;
	endtask

	// ############################################################
	// checks and run control
	// ############################################################

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("FAILED %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs_at_start = err_count;
		tests_run++;
	endtask

	task automatic end_test();
		if (err_count == test_errs_at_start) begin
			$display("test %s: passed", cur_test);
		end else begin
			$display("test %s: failed with %0d errors", cur_test, err_count - test_errs_at_start);
			tests_failed++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic start_run(input rc4_pkg::key_t key, input int len);
		logic [1:0] resp;
		write_reg(`RC4_REG_KEY, 32'(key), resp);
		check_value("key write resp", RESP_OKAY, resp);
		write_reg(`RC4_REG_CTRL, (32'(len) << 1) | 32'h1, resp);
		check_value("start resp", RESP_OKAY, resp);
	endtask

	task automatic wait_done(output rc4_pkg::axil_data_t status);
		logic [1:0] resp;
		read_reg(`RC4_REG_STATUS, status, resp);
		while (!status[1]) read_reg(`RC4_REG_STATUS, status, resp);
	endtask

	// waits for each byte so reads can overlap the engine
	task automatic read_and_compare(input int n);
		rc4_pkg::axil_data_t status;
		rc4_pkg::axil_data_t data;
		logic [1:0]          resp;
		for (int idx = 0; idx < n; idx++) begin
			read_reg(`RC4_REG_STATUS, status, resp);
			while (status[15:8] == 8'h0) read_reg(`RC4_REG_STATUS, status, resp);
			read_reg(`RC4_REG_DATA, data, resp);
			check_value($sformatf("byte %0d resp", idx), RESP_OKAY, resp);
			check_value($sformatf("byte %0d", idx), 32'(exp_q[idx]), data);
		end
	endtask

	// ############################################################
	// tests
	// ############################################################

	task automatic fixed_key_run();
		rc4_pkg::axil_data_t status;
		start_test("fixed_key");
		build_expected(24'h010203, 16);
		start_run(24'h010203, 16);
		wait_done(status);
		check_value("count at done", 16, status[15:8]);
		read_and_compare(16);
		end_test();
	endtask

	task automatic random_key_runs();
		rc4_pkg::axil_data_t status;
		rc4_pkg::key_t       key;
		int                  len;
		start_test("random_keys");
		for (int r = 0; r < 8; r++) begin
			key = rc4_pkg::key_t'($urandom);
			len = 1 + ($urandom % 32);
			build_expected(key, len);
			start_run(key, len);
			wait_done(status);
			check_value($sformatf("run %0d count", r), 32'(len), status[15:8]);
			check_value($sformatf("run %0d busy", r), 0, status[0]);
			read_and_compare(len);
		end
		end_test();
	endtask

	task automatic backpressure_run();
		rc4_pkg::axil_data_t status;
		logic [1:0]          resp;
		start_test("backpressure");
		build_expected(24'hc0ffee, 32);
		start_run(24'hc0ffee, 32);
		wait_done(status);
		check_value("count at done", `RC4_FIFO_DEPTH, status[15:8]);
		read_and_compare(32);
		// longer than the FIFO so the engine stalls when full
		build_expected(24'h5a17e3, 48);
		start_run(24'h5a17e3, 48);
		read_reg(`RC4_REG_STATUS, status, resp);
		while (status[15:8] != 8'(`RC4_FIFO_DEPTH)) read_reg(`RC4_REG_STATUS, status, resp);
		read_reg(`RC4_REG_STATUS, status, resp);
		check_value("stalled busy", 1, status[0]);
		check_value("stalled count", `RC4_FIFO_DEPTH, status[15:8]);
		read_and_compare(48);
		wait_done(status);
		check_value("count after drain", 0, status[15:8]);
		end_test();
	endtask

	task automatic busy_refusal();
		rc4_pkg::axil_data_t status;
		logic [1:0]          resp;
		start_test("busy_refusal");
		build_expected(24'h3c9a01, 8);
		start_run(24'h3c9a01, 8);
		read_reg(`RC4_REG_STATUS, status, resp);
		check_value("busy after start", 1, status[0]);
		write_reg(`RC4_REG_KEY, 32'h00ab_cdef, resp);
		write_reg(`RC4_REG_CTRL, (32'd20 << 1) | 32'h1, resp);
		check_value("start while busy", RESP_SLVERR, resp);
		wait_done(status);
		check_value("count at done", 8, status[15:8]);
		read_and_compare(8);
		end_test();
	endtask

	task automatic error_responses();
		rc4_pkg::axil_data_t data;
		logic [1:0]          resp;
		start_test("error_responses");
		read_reg(`RC4_REG_DATA, data, resp);
		check_value("empty read resp", RESP_SLVERR, resp);
		check_value("empty read data", 0, data);
		read_reg(4'h6, data, resp);
		check_value("unmapped read resp", RESP_SLVERR, resp);
		write_reg(4'ha, 32'h1234_5678, resp);
		check_value("unmapped write resp", RESP_SLVERR, resp);
		end_test();
	endtask

	task automatic reset_restart();
		rc4_pkg::axil_data_t status;
		rc4_pkg::axil_data_t data;
		logic [1:0]          resp;
		start_test("reset_restart");
		apply_reset();
		read_reg(`RC4_REG_STATUS, status, resp);
		check_value("status after reset", 0, status);
		build_expected(24'h112233, 10);
		start_run(24'h112233, 10);
		wait_done(status);
		read_and_compare(3);
		// seven bytes left behind for the next start to flush
		build_expected(24'h8e0f42, 5);
		start_run(24'h8e0f42, 5);
		wait_done(status);
		check_value("count after restart", 5, status[15:8]);
		read_and_compare(5);
		read_reg(`RC4_REG_DATA, data, resp);
		check_value("read past new run", RESP_SLVERR, resp);
		end_test();
	endtask

	initial begin
		req          = '0;
		rst_n        = 1'b0;
		err_count    = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(32'h8290ec23));
		apply_reset();

		fixed_key_run();
		random_key_runs();
		backpressure_run();
		busy_refusal();
		error_responses();
		reset_restart();

		$display("tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/rc4_pkg.sv
src/rc4_reg_decode.sv
src/rc4_engine.sv
src/rc4_state_ram.sv
src/rc4_keystream_fifo.sv
src/rc4_top.sv
tests/tb_rc4_top.sv

// ==== Bender.yml ====
package:
  name: rc4_keystream

sources:
  - include_dirs:
      - src
    files:
      - src/rc4_pkg.sv
      - src/rc4_reg_decode.sv
      - src/rc4_engine.sv
      - src/rc4_state_ram.sv
      - src/rc4_keystream_fifo.sv
      - src/rc4_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_rc4_top.sv
